/* hdl/order_mon_pkg.sv */
// widths, beat structs and error codes shared by the AXI read order monitor
package order_mon_pkg;

  // AXI ID width is fixed for the whole monitor
  localparam int unsigned ID_W = 2;
  localparam int unsigned NUM_IDS = 2 ** ID_W;

  typedef logic [31:0]     addr_t;
  typedef logic [31:0]     data_t;
  typedef logic [7:0]      len_t;
  typedef logic [1:0]      resp_t;
  typedef logic [ID_W-1:0] id_t;

  // read address beat, only the fields the check looks at
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_beat_t;

  // read data beat
  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_beat_t;

  // lower value means higher priority when errors coincide
  typedef enum logic [2:0] {
    err_none          = 3'd0,
    err_no_region     = 3'd1,
    err_ar_unexpected = 3'd2,
    err_ar_mismatch   = 3'd3,
    err_r_unexpected  = 3'd4,
    err_r_mismatch    = 3'd5,
    err_overflow      = 3'd6
  } mon_err_e;

endpackage

/* hdl/sync_fifo.sv */
// synchronous circular-buffer FIFO with full and empty flags
module sync_fifo #(
  parameter int unsigned Depth = 4,
  parameter type entry_t = logic
) (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   push_i,
  input  entry_t data_i,
  input  logic   pop_i,
  output entry_t data_o,
  output logic   full_o,
  output logic   empty_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  entry_t          mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push;
  logic            do_pop;

  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);
  // a push into a full buffer or a pop from an empty one is dropped here
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

/* hdl/region_decode.sv */
// address to slave index decoder over a base/mask rule table
module region_decode import order_mon_pkg::*; #(
  parameter int unsigned NumSlaves = 2,
  parameter addr_t [NumSlaves-1:0] RegionBase = '0,
  parameter addr_t [NumSlaves-1:0] RegionMask = '0,
  localparam int unsigned IdxW = (NumSlaves > 1) ? $clog2(NumSlaves) : 1
) (
  input  addr_t           addr_i,
  output logic [IdxW-1:0] slv_idx_o,
  output logic            hit_o
);

  // walk downwards so the lowest matching rule is the last one written
  always_comb begin
    slv_idx_o = '0;
    hit_o     = 1'b0;
    for (int s = NumSlaves - 1; s >= 0; s--) begin
      if ((addr_i & RegionMask[s]) == RegionBase[s]) begin
        slv_idx_o = IdxW'(s);
        hit_o     = 1'b1;
      end
    end
  end

endmodule

/* hdl/ar_forward_check.sv */
// per-slave check of forwarded AR beats and list of accepted IDs for R labeling
module ar_forward_check import order_mon_pkg::*; #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     exp_push_i,
  input  ar_beat_t exp_ar_i,
  input  logic     slv_fire_i,
  input  ar_beat_t slv_ar_i,
  input  logic     id_pop_i,
  output id_t      head_id_o,
  output logic     id_valid_o,
  output logic     err_o,
  output mon_err_e err_code_o,
  output logic     idle_o
);

  ar_beat_t exp_head;
  logic     exp_full;
  logic     exp_empty;
  logic     exp_pop;
  logic     id_full;
  logic     id_empty;
  logic     fields_match;

  // ARs issued by the master and routed to this slave
  sync_fifo #(
    .Depth   (FifoDepth),
    .entry_t (ar_beat_t)
  ) exp_fifo_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (exp_push_i),
    .data_i  (exp_ar_i),
    .pop_i   (exp_pop),
    .data_o  (exp_head),
    .full_o  (exp_full),
    .empty_o (exp_empty)
  );

  // master IDs of ARs the slave accepted, oldest first
  sync_fifo #(
    .Depth   (FifoDepth),
    .entry_t (id_t)
  ) id_fifo_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (exp_pop),
    .data_i  (exp_head.id),
    .pop_i   (id_pop_i),
    .data_o  (head_id_o),
    .full_o  (id_full),
    .empty_o (id_empty)
  );

  // slave side ID is remapped by the interconnect so only addr and len count
  assign fields_match = (slv_ar_i.addr == exp_head.addr) && (slv_ar_i.len == exp_head.len);
  assign exp_pop      = slv_fire_i && !exp_empty && fields_match;
  assign id_valid_o   = !id_empty;
  assign idle_o       = exp_empty && id_empty;

  // one event per cycle, lowest code first
  always_comb begin
    err_code_o = err_none;
    if (slv_fire_i && exp_empty) begin
      err_code_o = err_ar_unexpected;
    end else if (slv_fire_i && !fields_match) begin
      err_code_o = err_ar_mismatch;
    end else if ((exp_push_i && exp_full) || (exp_pop && id_full)) begin
      err_code_o = err_overflow;
    end
  end

  assign err_o = (err_code_o != err_none);

endmodule

/* hdl/r_return_check.sv */
// R beat labeling, per-ID route lists and master side R comparison
module r_return_check import order_mon_pkg::*; #(
  parameter int unsigned NumSlaves = 2,
  parameter int unsigned FifoDepth = 4,
  localparam int unsigned IdxW = (NumSlaves > 1) ? $clog2(NumSlaves) : 1
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      route_push_i,
  input  id_t                       route_id_i,
  input  logic [IdxW-1:0]           route_slv_i,
  input  logic [NumSlaves-1:0]      slv_r_fire_i,
  input  r_beat_t [NumSlaves-1:0]   slv_r_i,
  input  id_t [NumSlaves-1:0]       head_id_i,
  input  logic [NumSlaves-1:0]      id_valid_i,
  input  logic                      mst_r_fire_i,
  input  r_beat_t                   mst_r_i,
  output logic [NumSlaves-1:0]      id_pop_o,
  output logic                      err_o,
  output mon_err_e                  err_code_o,
  output logic                      idle_o
);

  typedef logic [IdxW-1:0] slv_idx_t;

  slv_idx_t [NUM_IDS-1:0]                 route_head;
  logic [NUM_IDS-1:0]                     route_push;
  logic [NUM_IDS-1:0]                     route_pop;
  logic [NUM_IDS-1:0]                     route_full;
  logic [NUM_IDS-1:0]                     route_empty;
  r_beat_t [NumSlaves-1:0]                beat_in;
  r_beat_t [NumSlaves-1:0][NUM_IDS-1:0]   beat_head;
  logic [NumSlaves-1:0][NUM_IDS-1:0]      beat_push;
  logic [NumSlaves-1:0][NUM_IDS-1:0]      beat_pop;
  logic [NumSlaves-1:0][NUM_IDS-1:0]      beat_full;
  logic [NumSlaves-1:0][NUM_IDS-1:0]      beat_empty;
  slv_idx_t                               mst_slv;
  r_beat_t                                exp_beat;
  logic                                   route_hit;
  logic                                   beat_hit;

  // slave order of outstanding reads, one list per ID
  for (genvar x = 0; x < NUM_IDS; x++) begin : gen_route
    assign route_push[x] = route_push_i && (route_id_i == id_t'(x));
    // a burst ends on last, then the next read of this ID may answer
    assign route_pop[x]  = mst_r_fire_i && mst_r_i.last && (mst_r_i.id == id_t'(x));

    sync_fifo #(
      .Depth   (FifoDepth),
      .entry_t (slv_idx_t)
    ) route_fifo_i (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .push_i  (route_push[x]),
      .data_i  (route_slv_i),
      .pop_i   (route_pop[x]),
      .data_o  (route_head[x]),
      .full_o  (route_full[x]),
      .empty_o (route_empty[x])
    );
  end

  for (genvar s = 0; s < NumSlaves; s++) begin : gen_slv
    // restore the master ID from the oldest accepted AR of this slave
    assign beat_in[s] = '{
      id:   head_id_i[s],
      data: slv_r_i[s].data,
      resp: slv_r_i[s].resp,
      last: slv_r_i[s].last
    };
    assign id_pop_o[s] = slv_r_fire_i[s] && slv_r_i[s].last && id_valid_i[s];

    for (genvar x = 0; x < NUM_IDS; x++) begin : gen_id
      assign beat_push[s][x] = slv_r_fire_i[s] && id_valid_i[s] &&
                               (head_id_i[s] == id_t'(x));
      assign beat_pop[s][x]  = mst_r_fire_i && route_hit &&
                               (mst_slv == slv_idx_t'(s)) && (mst_r_i.id == id_t'(x));

      sync_fifo #(
        .Depth   (FifoDepth),
        .entry_t (r_beat_t)
      ) beat_fifo_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .push_i  (beat_push[s][x]),
        .data_i  (beat_in[s]),
        .pop_i   (beat_pop[s][x]),
        .data_o  (beat_head[s][x]),
        .full_o  (beat_full[s][x]),
        .empty_o (beat_empty[s][x])
      );
    end
  end

  // expected beat for the master R, found through the route list of its ID
  assign mst_slv   = route_head[mst_r_i.id];
  assign route_hit = !route_empty[mst_r_i.id];
  assign beat_hit  = route_hit && !beat_empty[mst_slv][mst_r_i.id];
  assign exp_beat  = beat_head[mst_slv][mst_r_i.id];

  always_comb begin
    err_code_o = err_none;
    if (|(slv_r_fire_i & ~id_valid_i) || (mst_r_fire_i && !beat_hit)) begin
      err_code_o = err_r_unexpected;
    end else if (mst_r_fire_i && (mst_r_i != exp_beat)) begin
      err_code_o = err_r_mismatch;
    end else if (|(route_push & route_full) || |(beat_push & beat_full)) begin
      err_code_o = err_overflow;
    end
  end

  assign err_o  = (err_code_o != err_none);
  assign idle_o = (&route_empty) && (&beat_empty);

endmodule

/* hdl/axi_read_order_mon.sv */
// AXI read order monitor top with decode, AR and R checkers and first-error capture
module axi_read_order_mon import order_mon_pkg::*; #(
  parameter int unsigned NumSlaves = 2,
  parameter int unsigned FifoDepth = 4,
  parameter addr_t [NumSlaves-1:0] RegionBase = {32'h1000_0000, 32'h0000_0000},
  parameter addr_t [NumSlaves-1:0] RegionMask = {32'hF000_0000, 32'hF000_0000},
  localparam int unsigned IdxW = (NumSlaves > 1) ? $clog2(NumSlaves) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     mst_ar_valid_i,
  input  logic                     mst_ar_ready_i,
  input  ar_beat_t                 mst_ar_i,
  input  logic                     mst_r_valid_i,
  input  logic                     mst_r_ready_i,
  input  r_beat_t                  mst_r_i,
  input  logic [NumSlaves-1:0]     slv_ar_valid_i,
  input  logic [NumSlaves-1:0]     slv_ar_ready_i,
  input  ar_beat_t [NumSlaves-1:0] slv_ar_i,
  input  logic [NumSlaves-1:0]     slv_r_valid_i,
  input  logic [NumSlaves-1:0]     slv_r_ready_i,
  input  r_beat_t [NumSlaves-1:0]  slv_r_i,
  output logic                     error_o,
  output mon_err_e                 error_code_o,
  output logic                     idle_o
);

  logic                 mst_ar_fire;
  logic                 mst_r_fire;
  logic [NumSlaves-1:0] slv_ar_fire;
  logic [NumSlaves-1:0] slv_r_fire;
  logic [IdxW-1:0]      ar_slv_idx;
  logic                 ar_hit;
  logic [NumSlaves-1:0] ar_push;
  id_t [NumSlaves-1:0]  head_id;
  logic [NumSlaves-1:0] id_valid;
  logic [NumSlaves-1:0] id_pop;
  logic [NumSlaves-1:0] ar_err;
  mon_err_e             ar_err_code [NumSlaves];
  logic [NumSlaves-1:0] ar_idle;
  logic                 r_err;
  mon_err_e             r_err_code;
  logic                 r_idle;
  logic                 evt_valid;
  mon_err_e             evt_code;
  logic                 error_q;
  mon_err_e             error_code_q;

  // passive monitor, a transfer is any cycle with valid and ready high
  assign mst_ar_fire = mst_ar_valid_i && mst_ar_ready_i;
  assign mst_r_fire  = mst_r_valid_i && mst_r_ready_i;
  assign slv_ar_fire = slv_ar_valid_i & slv_ar_ready_i;
  assign slv_r_fire  = slv_r_valid_i & slv_r_ready_i;

  region_decode #(
    .NumSlaves  (NumSlaves),
    .RegionBase (RegionBase),
    .RegionMask (RegionMask)
  ) region_decode_i (
    .addr_i    (mst_ar_i.addr),
    .slv_idx_o (ar_slv_idx),
    .hit_o     (ar_hit)
  );

  for (genvar s = 0; s < NumSlaves; s++) begin : gen_ar_check
    assign ar_push[s] = mst_ar_fire && ar_hit && (ar_slv_idx == IdxW'(s));

    ar_forward_check #(
      .FifoDepth (FifoDepth)
    ) ar_forward_check_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .exp_push_i (ar_push[s]),
      .exp_ar_i   (mst_ar_i),
      .slv_fire_i (slv_ar_fire[s]),
      .slv_ar_i   (slv_ar_i[s]),
      .id_pop_i   (id_pop[s]),
      .head_id_o  (head_id[s]),
      .id_valid_o (id_valid[s]),
      .err_o      (ar_err[s]),
      .err_code_o (ar_err_code[s]),
      .idle_o     (ar_idle[s])
    );
  end

  r_return_check #(
    .NumSlaves (NumSlaves),
    .FifoDepth (FifoDepth)
  ) r_return_check_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .route_push_i (mst_ar_fire && ar_hit),
    .route_id_i   (mst_ar_i.id),
    .route_slv_i  (ar_slv_idx),
    .slv_r_fire_i (slv_r_fire),
    .slv_r_i      (slv_r_i),
    .head_id_i    (head_id),
    .id_valid_i   (id_valid),
    .mst_r_fire_i (mst_r_fire),
    .mst_r_i      (mst_r_i),
    .id_pop_o     (id_pop),
    .err_o        (r_err),
    .err_code_o   (r_err_code),
    .idle_o       (r_idle)
  );

  // pick the lowest error code among this cycle's events
  always_comb begin
    evt_valid = 1'b0;
    evt_code  = err_none;
    if (mst_ar_fire && !ar_hit) begin
      evt_valid = 1'b1;
      evt_code  = err_no_region;
    end
    for (int s = 0; s < NumSlaves; s++) begin
      if (ar_err[s] && (!evt_valid || (ar_err_code[s] < evt_code))) begin
        evt_valid = 1'b1;
        evt_code  = ar_err_code[s];
      end
    end
    if (r_err && (!evt_valid || (r_err_code < evt_code))) begin
      evt_valid = 1'b1;
      evt_code  = r_err_code;
    end
  end

  // first error sticks until reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      error_q      <= 1'b0;
      error_code_q <= err_none;
    end else if (evt_valid && !error_q) begin
      error_q      <= 1'b1;
      error_code_q <= evt_code;
    end
  end

  assign error_o      = error_q;
  assign error_code_o = error_code_q;
  assign idle_o       = (&ar_idle) && r_idle;

endmodule

/* verif/axi_read_order_mon_properties.sv */
// concurrent assertions on error stickiness, error code consistency and idle after reset
module axi_read_order_mon_properties import order_mon_pkg::*; (
  input logic     clk_i,
  input logic     rst_i,
  input logic     error_i,
  input mon_err_e error_code_i,
  input logic     idle_i
);

  // first error holds until the next reset
  error_sticky: assert property (@(posedge clk_i) disable iff (rst_i) error_i |=> error_i)
    else $error("error_o fell without a reset");

  // code and flag always agree
  code_matches_flag: assert property (@(posedge clk_i) disable iff (rst_i)
    (error_code_i != err_none) == error_i)
    else $error("error_code_o disagrees with error_o");

  // all FIFOs start out empty
  idle_after_reset: assert property (@(posedge clk_i) rst_i |=> idle_i)
    else $error("idle_o low right after reset");

endmodule

bind axi_read_order_mon axi_read_order_mon_properties axi_read_order_mon_properties_i (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .error_i      (error_o),
  .error_code_i (error_code_o),
  .idle_i       (idle_o)
);

/* verif/tb_axi_read_order_mon.sv */
// testbench for the AXI read order monitor with event table, apply loop, checks and timeout
module tb_axi_read_order_mon import order_mon_pkg::*;;

  localparam addr_t [1:0] region_base = {32'h1000_0000, 32'h0000_0000};
  localparam addr_t [1:0] region_mask = {32'hF000_0000, 32'hF000_0000};

  // channel kinds in the event table
  localparam logic [1:0] kind_mst_ar = 2'd0;
  localparam logic [1:0] kind_slv_ar = 2'd1;
  localparam logic [1:0] kind_slv_r  = 2'd2;
  localparam logic [1:0] kind_mst_r  = 2'd3;

  typedef struct packed {
    logic [1:0] kind;
    logic       slv;
    ar_beat_t   ar;
    r_beat_t    r;
    logic       do_rst;
    mon_err_e   exp_code;
    logic       exp_idle;
  } row_t;

  logic                 clk_i;
  logic                 rst_i;
  logic                 mst_ar_valid_i;
  logic                 mst_ar_ready_i;
  ar_beat_t             mst_ar_i;
  logic                 mst_r_valid_i;
  logic                 mst_r_ready_i;
  r_beat_t              mst_r_i;
  logic [1:0]           slv_ar_valid_i;
  logic [1:0]           slv_ar_ready_i;
  ar_beat_t [1:0]       slv_ar_i;
  logic [1:0]           slv_r_valid_i;
  logic [1:0]           slv_r_ready_i;
  r_beat_t [1:0]        slv_r_i;
  logic                 error_o;
  mon_err_e             error_code_o;
  logic                 idle_o;

  row_t   rows [$];
  data_t  rnd_data [6];
  integer seed = 32'h5a62;
  int     cycle_cnt = 0;
  int     timeout_cycles = 0;

  axi_read_order_mon #(
    .NumSlaves  (2),
    .FifoDepth  (4),
    .RegionBase (region_base),
    .RegionMask (region_mask)
  ) axi_read_order_mon_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .mst_ar_valid_i (mst_ar_valid_i),
    .mst_ar_ready_i (mst_ar_ready_i),
    .mst_ar_i       (mst_ar_i),
    .mst_r_valid_i  (mst_r_valid_i),
    .mst_r_ready_i  (mst_r_ready_i),
    .mst_r_i        (mst_r_i),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_ready_i (slv_ar_ready_i),
    .slv_ar_i       (slv_ar_i),
    .slv_r_valid_i  (slv_r_valid_i),
    .slv_r_ready_i  (slv_r_ready_i),
    .slv_r_i        (slv_r_i),
    .error_o        (error_o),
    .error_code_o   (error_code_o),
    .idle_o         (idle_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (timeout_cycles > 0 && cycle_cnt >= timeout_cycles) begin
      $display("timeout after %0d cycles, the event table did not finish", cycle_cnt);
      $display("TESTS FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic add_ar_row(input logic [1:0] kind, input logic slv, input id_t id,
                            input addr_t addr, input len_t len, input logic do_rst,
                            input mon_err_e exp_code, input logic exp_idle);
    row_t rw;
    rw          = '0;
    rw.kind     = kind;
    rw.slv      = slv;
    rw.ar.id    = id;
    rw.ar.addr  = addr;
    rw.ar.len   = len;
    rw.do_rst   = do_rst;
    rw.exp_code = exp_code;
    rw.exp_idle = exp_idle;
    rows.push_back(rw);
  endtask

  task automatic add_r_row(input logic [1:0] kind, input logic slv, input id_t id,
                           input data_t data, input logic last, input logic do_rst,
                           input mon_err_e exp_code, input logic exp_idle);
    row_t rw;
    rw          = '0;
    rw.kind     = kind;
    rw.slv      = slv;
    rw.r.id     = id;
    rw.r.data   = data;
    rw.r.resp   = 2'b00;
    rw.r.last   = last;
    rw.do_rst   = do_rst;
    rw.exp_code = exp_code;
    rw.exp_idle = exp_idle;
    rows.push_back(rw);
  endtask

  task automatic build_table();
    for (int i = 0; i < 6; i++) begin
      rnd_data[i] = $random(seed);
    end
    // the misordered beat must differ from the expected one
    if (rnd_data[4] == rnd_data[5]) begin
      rnd_data[5] = ~rnd_data[4];
    end
    // two-beat read through slave 1 with a remapped slave side ID
    add_ar_row(kind_mst_ar, 1'b1, 2'd2, 32'h1000_0040, 8'd1, 1'b0, err_none, 1'b0);
    add_ar_row(kind_slv_ar, 1'b1, 2'd3, 32'h1000_0040, 8'd1, 1'b0, err_none, 1'b0);
    add_r_row(kind_slv_r, 1'b1, 2'd3, rnd_data[0], 1'b0, 1'b0, err_none, 1'b0);
    add_r_row(kind_slv_r, 1'b1, 2'd3, rnd_data[1], 1'b1, 1'b0, err_none, 1'b0);
    add_r_row(kind_mst_r, 1'b0, 2'd2, rnd_data[0], 1'b0, 1'b0, err_none, 1'b0);
    add_r_row(kind_mst_r, 1'b0, 2'd2, rnd_data[1], 1'b1, 1'b0, err_none, 1'b1);
    // ID 1 to slave 0 then slave 1 where slave 1 answers first
    add_ar_row(kind_mst_ar, 1'b0, 2'd1, 32'h0000_0100, 8'd0, 1'b0, err_none, 1'b0);
    add_ar_row(kind_mst_ar, 1'b0, 2'd1, 32'h1000_0200, 8'd0, 1'b0, err_none, 1'b0);
    add_ar_row(kind_slv_ar, 1'b0, 2'd0, 32'h0000_0100, 8'd0, 1'b0, err_none, 1'b0);
    add_ar_row(kind_slv_ar, 1'b1, 2'd0, 32'h1000_0200, 8'd0, 1'b0, err_none, 1'b0);
    add_r_row(kind_slv_r, 1'b1, 2'd0, rnd_data[2], 1'b1, 1'b0, err_none, 1'b0);
    add_r_row(kind_slv_r, 1'b0, 2'd0, rnd_data[3], 1'b1, 1'b0, err_none, 1'b0);
    add_r_row(kind_mst_r, 1'b0, 2'd1, rnd_data[3], 1'b1, 1'b0, err_none, 1'b0);
    add_r_row(kind_mst_r, 1'b0, 2'd1, rnd_data[2], 1'b1, 1'b0, err_none, 1'b1);
    // forwarded address differs and then a slave AR nobody asked for
    add_ar_row(kind_mst_ar, 1'b0, 2'd0, 32'h0000_0200, 8'd0, 1'b1, err_none, 1'b0);
    add_ar_row(kind_slv_ar, 1'b0, 2'd0, 32'h0000_0204, 8'd0, 1'b0, err_ar_mismatch, 1'b0);
    add_ar_row(kind_slv_ar, 1'b0, 2'd0, 32'h0000_0200, 8'd0, 1'b1, err_ar_unexpected, 1'b1);
    // master sees slave 1 data before slave 0 data on the same ID
    add_ar_row(kind_mst_ar, 1'b0, 2'd1, 32'h0000_0100, 8'd0, 1'b1, err_none, 1'b0);
    add_ar_row(kind_mst_ar, 1'b0, 2'd1, 32'h1000_0200, 8'd0, 1'b0, err_none, 1'b0);
    add_ar_row(kind_slv_ar, 1'b0, 2'd0, 32'h0000_0100, 8'd0, 1'b0, err_none, 1'b0);
    add_ar_row(kind_slv_ar, 1'b1, 2'd0, 32'h1000_0200, 8'd0, 1'b0, err_none, 1'b0);
    add_r_row(kind_slv_r, 1'b1, 2'd0, rnd_data[4], 1'b1, 1'b0, err_none, 1'b0);
    add_r_row(kind_slv_r, 1'b0, 2'd0, rnd_data[5], 1'b1, 1'b0, err_none, 1'b0);
    add_r_row(kind_mst_r, 1'b0, 2'd1, rnd_data[4], 1'b1, 1'b0, err_r_mismatch, 1'b0);
    add_r_row(kind_mst_r, 1'b0, 2'd0, 32'h0, 1'b1, 1'b1, err_r_unexpected, 1'b1);
    // address outside every region
    add_ar_row(kind_mst_ar, 1'b0, 2'd0, 32'h3000_0000, 8'd0, 1'b1, err_no_region, 1'b1);
    // five ARs into a four deep FIFO
    add_ar_row(kind_mst_ar, 1'b0, 2'd3, 32'h0000_1000, 8'd0, 1'b1, err_none, 1'b0);
    add_ar_row(kind_mst_ar, 1'b0, 2'd3, 32'h0000_2000, 8'd0, 1'b0, err_none, 1'b0);
    add_ar_row(kind_mst_ar, 1'b0, 2'd3, 32'h0000_3000, 8'd0, 1'b0, err_none, 1'b0);
    add_ar_row(kind_mst_ar, 1'b0, 2'd3, 32'h0000_4000, 8'd0, 1'b0, err_none, 1'b0);
    add_ar_row(kind_mst_ar, 1'b0, 2'd3, 32'h0000_5000, 8'd0, 1'b0, err_overflow, 1'b0);
  endtask

  task automatic reset_dut();
    @(posedge clk_i);
    #5;
    rst_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #5;
    rst_i = 1'b0;
  endtask

  task automatic check_err(input int row, input mon_err_e expected, input mon_err_e actual);
    if (actual !== expected) begin
      $display("FAILED row %0d error_code_o: expected %h, actual %h", row, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "error code mismatch");
    end
  endtask

  task automatic check_error_flag(input int row, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED row %0d error_o: expected %h, actual %h", row, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "error flag mismatch");
    end
  endtask

  task automatic check_idle(input int row, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED row %0d idle_o: expected %h, actual %h", row, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "idle flag mismatch");
    end
  endtask

  task automatic clear_inputs();
    mst_ar_valid_i = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_r_valid_i  = 1'b0;
    mst_r_ready_i  = 1'b0;
    slv_ar_valid_i = '0;
    slv_ar_ready_i = '0;
    slv_r_valid_i  = '0;
    slv_r_ready_i  = '0;
  endtask

  task automatic apply_row(input int idx, input row_t rw);
    if (rw.do_rst) begin
      reset_dut();
    end
    @(posedge clk_i);
    #5;
    case (rw.kind)
      kind_mst_ar: begin
        mst_ar_valid_i = 1'b1;
        mst_ar_ready_i = 1'b1;
        mst_ar_i       = rw.ar;
      end
      kind_slv_ar: begin
        slv_ar_valid_i[rw.slv] = 1'b1;
        slv_ar_ready_i[rw.slv] = 1'b1;
        slv_ar_i[rw.slv]       = rw.ar;
      end
      kind_slv_r: begin
        slv_r_valid_i[rw.slv] = 1'b1;
        slv_r_ready_i[rw.slv] = 1'b1;
        slv_r_i[rw.slv]       = rw.r;
      end
      default: begin
        mst_r_valid_i = 1'b1;
        mst_r_ready_i = 1'b1;
        mst_r_i       = rw.r;
      end
    endcase
    // one transfer with results visible one cycle later
    @(posedge clk_i);
    #5;
    clear_inputs();
    check_err(idx, rw.exp_code, error_code_o);
    check_error_flag(idx, rw.exp_code != err_none, error_o);
    check_idle(idx, rw.exp_idle, idle_o);
  endtask

  initial begin
    rst_i    = 1'b1;
    mst_ar_i = '0;
    mst_r_i  = '0;
    slv_ar_i = '0;
    slv_r_i  = '0;
    clear_inputs();
    build_table();
    timeout_cycles = rows.size() * 4 + 20;
    repeat (2) @(posedge clk_i);
    #5;
    rst_i = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      apply_row(i, rows[i]);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* all.f */
hdl/order_mon_pkg.sv
hdl/sync_fifo.sv
hdl/region_decode.sv
hdl/ar_forward_check.sv
hdl/r_return_check.sv
hdl/axi_read_order_mon.sv
verif/axi_read_order_mon_properties.sv
verif/tb_axi_read_order_mon.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module tb_axi_read_order_mon -o tb_sim
./obj_dir/tb_sim 2>&1 | tee sim.log
if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
  exit 1
fi
exit 0
